//--- conv3x3_mac.f
+incdir+hw
hw/conv_pkg.sv
hw/window_multiplier.sv
hw/tree_add_level.sv
hw/result_saturate.sv
hw/conv3x3_mac.sv
verif/clk_gen.sv
verif/tb_conv3x3_mac.sv

//--- hw/conv3x3_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv3x3_mac
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     conv_en,
    input  tap_vec_t filter_taps,
    input  tap_vec_t window_taps,
    output tap_t     out_data,
    output logic     out_we
);

    prod_vec_t   prod;
    logic        prod_valid;
    sum_l1_vec_t l1_sums;
    logic        l1_valid;
    sum_l2_vec_t l2_sums;
    logic        l2_valid;
    sum_l3_vec_t l3_sums;
    logic        l3_valid;
    sum_l4_t     l4_sum;
    logic        l4_valid;

    //////////////////////////////////////////////////
    // Capture and multiply, 2 cycles
    //////////////////////////////////////////////////

    window_multiplier u_multiplier (
        .clk         (clk),
        .reset       (reset),
        .conv_en     (conv_en),
        .filter_taps (filter_taps),
        .window_taps (window_taps),
        .prod        (prod),
        .prod_valid  (prod_valid)
    );

    //////////////////////////////////////////////////
    // Adder tree 9 -> 5 -> 3 -> 2 -> 1
    //////////////////////////////////////////////////

    tree_add_level #(.in_t(prod_t), .out_t(sum_l1_t), .N_IN(9)) level_1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (prod_valid),
        .in_sums   (prod),
        .out_sums  (l1_sums),
        .out_valid (l1_valid)
    );

    tree_add_level #(.in_t(sum_l1_t), .out_t(sum_l2_t), .N_IN(5)) level_2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (l1_valid),
        .in_sums   (l1_sums),
        .out_sums  (l2_sums),
        .out_valid (l2_valid)
    );

    tree_add_level #(.in_t(sum_l2_t), .out_t(sum_l3_t), .N_IN(3)) level_3 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (l2_valid),
        .in_sums   (l2_sums),
        .out_sums  (l3_sums),
        .out_valid (l3_valid)
    );

    tree_add_level #(.in_t(sum_l3_t), .out_t(sum_l4_t), .N_IN(2)) level_4 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (l3_valid),
        .in_sums   (l3_sums),
        .out_sums  (l4_sum),
        .out_valid (l4_valid)
    );

    // Scale, clamp and strobe into the output memory
    result_saturate u_saturate (
        .clk       (clk),
        .reset     (reset),
        .sum_valid (l4_valid),
        .sum       (l4_sum),
        .out_data  (out_data),
        .out_we    (out_we)
    );

endmodule

`default_nettype wire

//--- hw/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

//////////////////////////////////////////////////
// 3x3 convolution MAC configuration
//////////////////////////////////////////////////

// Width of one coefficient, pixel or result
`define CONV_TAP_W 16

// Taps per 3x3 window
`define CONV_TAPS 9

// Q8.8 fraction bits
`define CONV_FRAC_BITS 8

// Sampled conv_en edge to out_we, counting the sampling edge.
// 2 multiplier stages, 4 adder levels, 1 output stage
`define CONV_LATENCY 7

`endif

//--- hw/conv_pkg.sv
`default_nettype none

package conv_pkg;

    `include "conv_cfg.svh"

    //////////////////////////////////////////////////
    // Operands
    //////////////////////////////////////////////////

    // Signed Q8.8
    typedef logic signed [`CONV_TAP_W-1:0] tap_t;

    // Row-major, index 0 is the top-left tap
    typedef tap_t [`CONV_TAPS-1:0] tap_vec_t;

    //////////////////////////////////////////////////
    // Products and adder tree
    //////////////////////////////////////////////////

    // Full Q16.16 product
    typedef logic signed [2*`CONV_TAP_W-1:0] prod_t;
    typedef prod_t [`CONV_TAPS-1:0] prod_vec_t;

    // One bit of growth per level
    typedef logic signed [2*`CONV_TAP_W:0] sum_l1_t;
    typedef sum_l1_t [4:0] sum_l1_vec_t;

    typedef logic signed [2*`CONV_TAP_W+1:0] sum_l2_t;
    typedef sum_l2_t [2:0] sum_l2_vec_t;

    typedef logic signed [2*`CONV_TAP_W+2:0] sum_l3_t;
    typedef sum_l3_t [1:0] sum_l3_vec_t;

    // Final sum of nine products, wide enough for the worst case
    typedef logic signed [2*`CONV_TAP_W+3:0] sum_l4_t;

endpackage

`default_nettype wire

//--- hw/result_saturate.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module result_saturate
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sum_valid,
    input  sum_l4_t sum,
    output tap_t    out_data,
    output logic    out_we
);

    localparam sum_l4_t TAP_MAX = sum_l4_t'(2 ** (`CONV_TAP_W - 1) - 1);
    localparam sum_l4_t TAP_MIN = -TAP_MAX - 1;

    sum_l4_t scaled;
    tap_t    clamped;

    // Q16.16 back to Q8.8 by an arithmetic shift, which floors negative sums
    assign scaled = sum >>> `CONV_FRAC_BITS;

    always_comb
    begin
        if (scaled > TAP_MAX)
            clamped = tap_t'(TAP_MAX);
        else if (scaled < TAP_MIN)
            clamped = tap_t'(TAP_MIN);
        else
            clamped = tap_t'(scaled);
    end

    always_ff @(posedge clk)
    begin
        if (sum_valid)
            out_data <= clamped;
    end

    // One write strobe per result
    always_ff @(posedge clk)
    begin
        if (reset)
            out_we <= 1'b0;
        else
            out_we <= sum_valid;
    end

    // Clamping never flips the sign of a result
    a_sign_kept: assert property (
        @(posedge clk) disable iff (reset)
        sum_valid |=> (out_data < 0) == ($past(sum) < 0)
    ) else $error("result_saturate: out_data sign differs from the sum");

endmodule

`default_nettype wire

//--- hw/tree_add_level.sv
`timescale 1ns/1ps
`default_nettype none

module tree_add_level
    import conv_pkg::*;
#(
    parameter type in_t  = prod_t,
    parameter type out_t = sum_l1_t,
    parameter int  N_IN  = 9
)
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  in_t  [N_IN-1:0]               in_sums,
    output out_t [(N_IN+1)/2-1:0]         out_sums,
    output logic                          out_valid
);

    localparam int N_OUT = (N_IN + 1) / 2;

    out_t [N_OUT-1:0] sum_next;
    longint           in_total;
    longint           out_total;

    //////////////////////////////////////////////////
    // Pairwise sums
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < N_IN / 2; i++)
            sum_next[i] = out_t'(in_sums[2*i]) + out_t'(in_sums[2*i+1]);

        // Unpaired last input goes up a level unchanged
        if (N_IN % 2 == 1)
            sum_next[N_OUT-1] = out_t'(in_sums[N_IN-1]);
    end

    //////////////////////////////////////////////////
    // Level register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (in_valid)
            out_sums <= sum_next;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    // Totals on both sides of the level
    always_comb
    begin
        in_total = 0;
        for (int i = 0; i < N_IN; i++)
            in_total = in_total + longint'(in_sums[i]);
        out_total = 0;
        for (int i = 0; i < N_OUT; i++)
            out_total = out_total + longint'(out_sums[i]);
    end

    // A level neither drops nor duplicates a partial sum
    a_total_kept: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |=> out_total == $past(in_total)
    ) else $error("tree_add_level: level sum differs from the sum of its inputs");

endmodule

`default_nettype wire

//--- hw/window_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module window_multiplier
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      conv_en,
    input  tap_vec_t  filter_taps,
    input  tap_vec_t  window_taps,
    output prod_vec_t prod,
    output logic      prod_valid
);

    tap_vec_t filter_q;
    tap_vec_t window_q;
    logic     op_valid;

    //////////////////////////////////////////////////
    // Operand capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (conv_en)
        begin
            filter_q <= filter_taps;
            window_q <= window_taps;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            op_valid <= 1'b0;
        else
            op_valid <= conv_en;
    end

    //////////////////////////////////////////////////
    // Nine signed products
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (op_valid)
        begin
            // Coefficient times the pixel in the same position
            for (int i = 0; i < `CONV_TAPS; i++)
                prod[i] <= prod_t'(filter_q[i]) * prod_t'(window_q[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            prod_valid <= 1'b0;
        else
            prod_valid <= op_valid;
    end

    // X on a sampled window would reach out_data six cycles later
    a_taps_known: assert property (
        @(posedge clk) disable iff (reset)
        conv_en |-> !$isunknown(filter_taps) && !$isunknown(window_taps)
    ) else $error("window_multiplier: unknown tap bits while conv_en is high");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the conv3x3_mac testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_conv3x3_mac
BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert \
    -f conv3x3_mac.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "TESTBENCH PASSED" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

echo "Simulation passed, log in $LOG"
exit 0

//--- verif/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_conv3x3_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module tb_conv3x3_mac
    import conv_pkg::*;
();

    localparam int WAIT_LIMIT = 100;

    logic     clk;
    logic     reset;
    logic     conv_en;
    tap_vec_t filter_taps;
    tap_vec_t window_taps;
    tap_t     out_data;
    logic     out_we;

    int   edge_cnt = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   seed_val;
    tap_t exp_q[$];
    int   we_edges[$];

    clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    conv3x3_mac dut (
        .clk         (clk),
        .reset       (reset),
        .conv_en     (conv_en),
        .filter_taps (filter_taps),
        .window_taps (window_taps),
        .out_data    (out_data),
        .out_we      (out_we)
    );

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    //////////////////////////////////////////////////
    // Reference model and output monitor
    //////////////////////////////////////////////////

    // Sum of products, floor division by 2^frac, clamp to tap range
    function automatic tap_t conv_ref(input tap_vec_t f, input tap_vec_t w);
        longint acc;
        longint q;
        longint div;
        longint hi;
        acc = 0;
        div = longint'(1) << `CONV_FRAC_BITS;
        hi = (longint'(1) << (`CONV_TAP_W - 1)) - 1;
        for (int i = 0; i < `CONV_TAPS; i++)
            acc = acc + longint'(f[i]) * longint'(w[i]);
        q = acc / div;
        if ((acc % div != 0) && (acc < 0))
            q = q - 1;
        if (q > hi)
            q = hi;
        else if (q < -hi - 1)
            q = -hi - 1;
        return tap_t'(q);
    endfunction

    function automatic tap_t rand_small();
        return tap_t'(int'($urandom_range(1023)) - 512);
    endfunction

    always @(negedge clk)
    begin
        tap_t exp_val;
        if (!reset && out_we)
        begin
            we_edges.push_back(edge_cnt);
            if (exp_q.size() == 0)
            begin
                $display("Unexpected out_we pulse at %0t with no window pending", $time);
                errors++;
            end
            else
            begin
                exp_val = exp_q.pop_front();
                if (out_data !== exp_val)
                begin
                    $display("** Error at %0t: out_data expected %0d, got %0d",
                             $time, exp_val, out_data);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Driver and pulse checks
    //////////////////////////////////////////////////

    // Called on a falling edge, returns on the next one
    task automatic send_window(input tap_vec_t f, input tap_vec_t w, input tap_t exp_val);
        filter_taps = f;
        window_taps = w;
        conv_en = 1'b1;
        exp_q.push_back(exp_val);
        @(negedge clk);
    endtask

    task automatic check_pulses(input int count, input int start_edge, input string name);
        int waited;
        waited = 0;
        conv_en = 1'b0;
        while (we_edges.size() < count && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (we_edges.size() < count)
        begin
            $display("%s: timed out waiting for %0d results, saw %0d",
                     name, count, we_edges.size());
            errors++;
        end
        // Extra pulses would land here
        repeat (3) @(negedge clk);
        if (we_edges.size() != count)
        begin
            $display("%s: expected %0d out_we pulses, saw %0d", name, count, we_edges.size());
            errors++;
        end
        for (int i = 0; i < we_edges.size() && i < count; i++)
        begin
            if (we_edges[i] != start_edge + `CONV_LATENCY + i)
            begin
                $display("** Error at %0t: out_we edge expected %0d, got %0d",
                         $time, start_edge + `CONV_LATENCY + i, we_edges[i]);
                errors++;
            end
        end
        if (exp_q.size() != 0)
        begin
            $display("%s: %0d windows never produced a result", name, exp_q.size());
            errors++;
        end
        exp_q.delete();
        we_edges.delete();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before)
        begin
            tests_failed++;
            $display("%-28s FAIL (%0d errors)", name, errors - err_before);
        end
        else
            $display("%-28s ok", name);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_idle();
        int err_before;
        err_before = errors;
        conv_en = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            if (out_we !== 1'b0)
            begin
                $display("** Error at %0t: out_we expected 0, got %b", $time, out_we);
                errors++;
            end
        end
        we_edges.delete();
        finish_test("reset and idle", err_before);
    endtask

    task automatic test_identity();
        int       err_before;
        int       start_edge;
        tap_vec_t f;
        tap_vec_t w;
        err_before = errors;
        f = '0;
        f[4] = tap_t'(256);
        for (int i = 0; i < `CONV_TAPS; i++)
            w[i] = tap_t'($urandom);
        start_edge = edge_cnt;
        send_window(f, w, w[4]);
        check_pulses(1, start_edge, "identity");
        finish_test("identity kernel and latency", err_before);
    endtask

    // Only tap 8 is nonzero, so the result rides the unpaired path
    task automatic test_odd_tap();
        int       err_before;
        int       start_edge;
        tap_vec_t f;
        tap_vec_t w;
        err_before = errors;
        start_edge = edge_cnt;
        for (int n = 0; n < 4; n++)
        begin
            f = '0;
            w = '0;
            f[8] = rand_small();
            w[8] = rand_small();
            if (f[8] == 0)
                f[8] = tap_t'(300);
            if (w[8] == 0)
                w[8] = tap_t'(-300);
            send_window(f, w, conv_ref(f, w));
        end
        check_pulses(4, start_edge, "odd tap");
        finish_test("odd-tap passthrough", err_before);
    endtask

    task automatic test_stream();
        int       err_before;
        int       start_edge;
        tap_vec_t f;
        tap_vec_t w;
        err_before = errors;
        start_edge = edge_cnt;
        for (int n = 0; n < 30; n++)
        begin
            for (int i = 0; i < `CONV_TAPS; i++)
            begin
                f[i] = rand_small();
                w[i] = rand_small();
            end
            send_window(f, w, conv_ref(f, w));
        end
        check_pulses(30, start_edge, "stream");
        finish_test("back-to-back stream", err_before);
    endtask

    task automatic test_saturation();
        int       err_before;
        int       start_edge;
        tap_vec_t f;
        tap_vec_t w;
        err_before = errors;
        start_edge = edge_cnt;
        f = {`CONV_TAPS{tap_t'(16'h7fff)}};
        w = {`CONV_TAPS{tap_t'(16'h7fff)}};
        send_window(f, w, tap_t'(16'h7fff));
        w = {`CONV_TAPS{tap_t'(16'h8000)}};
        send_window(f, w, tap_t'(16'h8000));
        // Raw sum of -1 floors to -1, truncation would give 0
        f = '0;
        w = '0;
        f[0] = tap_t'(1);
        w[0] = tap_t'(-1);
        send_window(f, w, tap_t'(-1));
        check_pulses(3, start_edge, "saturation");
        finish_test("saturation and floor", err_before);
    endtask

    initial
    begin
        int waited;
        conv_en = 1'b0;
        filter_taps = '0;
        window_taps = '0;
        seed_val = $urandom(53026);
        waited = 0;
        while (reset !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0)
        begin
            $display("Reset was never released");
            errors++;
        end
        @(negedge clk);

        test_reset_idle();
        test_identity();
        test_odd_tap();
        test_stream();
        test_saturation();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
